/* common/dcache_settings.svh */
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// ------------------------------
// cache geometry
// ------------------------------

// associativity and number of sets
`define DCACHE_WAYS 2
`define DCACHE_SETS 16

// line and word size in bits
`define DCACHE_LINE_BITS 128
`define DCACHE_WORD_BITS 64

// core byte address width
`define DCACHE_ADDR_BITS 32

// ------------------------------
// derived widths
// ------------------------------
`define DCACHE_INDEX_BITS ($clog2(`DCACHE_SETS))
`define DCACHE_OFFSET_BITS ($clog2(`DCACHE_LINE_BITS / 8))
`define DCACHE_TAG_BITS (`DCACHE_ADDR_BITS - `DCACHE_INDEX_BITS - `DCACHE_OFFSET_BITS)
`define DCACHE_WORDS (`DCACHE_LINE_BITS / `DCACHE_WORD_BITS)
`define DCACHE_WOFF_BITS ($clog2(`DCACHE_WORDS))
`define DCACHE_BE_BITS (`DCACHE_WORD_BITS / 8)
`define DCACHE_ID_BITS 4

`endif

/* common/dcache_pkg.sv */
`include "dcache_settings.svh"

package dcache_pkg;

  // ------------------------------
  // core side
  // ------------------------------

  // request as issued by the core
  typedef struct packed {
    logic [`DCACHE_ADDR_BITS-1:0] addr;
    logic                         we;
    logic [`DCACHE_BE_BITS-1:0]   be;
    logic [`DCACHE_WORD_BITS-1:0] wdata;
    logic [`DCACHE_ID_BITS-1:0]   id;
  } core_req_t;

  // response, rdata is zero for stores
  typedef struct packed {
    logic [`DCACHE_WORD_BITS-1:0] rdata;
    logic [`DCACHE_ID_BITS-1:0]   id;
  } core_rsp_t;

  // request after the address split
  typedef struct packed {
    logic [`DCACHE_TAG_BITS-1:0]   tag;
    logic [`DCACHE_INDEX_BITS-1:0] index;
    logic [`DCACHE_WOFF_BITS-1:0]  offset;
    logic                          we;
    logic [`DCACHE_BE_BITS-1:0]    be;
    logic [`DCACHE_WORD_BITS-1:0]  wdata;
    logic [`DCACHE_ID_BITS-1:0]    id;
  } dec_req_t;

  // ------------------------------
  // memory side
  // ------------------------------

  // line aligned address, loads always fetch the whole line
  typedef struct packed {
    logic [`DCACHE_ADDR_BITS-1:0] addr;
    logic                         we;
    logic [`DCACHE_BE_BITS-1:0]   be;
    logic [`DCACHE_WORD_BITS-1:0] wdata;
    logic [`DCACHE_WOFF_BITS-1:0] offset;
  } miss_req_t;

  typedef struct packed {
    logic [`DCACHE_LINE_BITS-1:0] data;
  } refill_t;

  // ------------------------------
  // array payloads
  // ------------------------------
  typedef struct packed {
    logic                        valid;
    logic [`DCACHE_TAG_BITS-1:0] tag;
  } tag_entry_t;

  typedef logic [`DCACHE_LINE_BITS-1:0] line_t;

  // where the response word comes from
  typedef enum logic [1:0] {
    SEL_HIT,
    SEL_REFILL,
    SEL_STORE
  } sel_src_e;

endpackage

/* source/req_decode.sv */
`timescale 1ns/1ps
`include "dcache_settings.svh"

module req_decode (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // core request
  input  logic                  req_valid_i,
  input  dcache_pkg::core_req_t req_i,
  output logic                  req_ready_o,
  // decoded request towards the lookup
  output logic                  dec_valid_o,
  output dcache_pkg::dec_req_t  dec_req_o,
  input  logic                  dec_ready_i
);

  import dcache_pkg::*;

  logic     full_q;
  dec_req_t entry_q;
  dec_req_t entry_d;

  // accept when empty or when the held entry leaves this cycle
  assign req_ready_o = !full_q || dec_ready_i;

  // split the byte address into tag, set index and word offset
  always_comb begin
    entry_d.tag    = req_i.addr[`DCACHE_ADDR_BITS-1 -: `DCACHE_TAG_BITS];
    entry_d.index  = req_i.addr[`DCACHE_OFFSET_BITS +: `DCACHE_INDEX_BITS];
    entry_d.offset = req_i.addr[`DCACHE_OFFSET_BITS-1 -: `DCACHE_WOFF_BITS];
    entry_d.we     = req_i.we;
    entry_d.be     = req_i.be;
    entry_d.wdata  = req_i.wdata;
    entry_d.id     = req_i.id;
  end

  // occupancy flag
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (req_valid_i && req_ready_o) begin
      full_q <= 1'b1;
    end else if (dec_ready_i) begin
      full_q <= 1'b0;
    end
  end

  // held request
  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      entry_q <= entry_d;
    end
  end

  assign dec_valid_o = full_q;
  assign dec_req_o   = entry_q;

  // a stalled entry must not change until the lookup takes it
  a_dec_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dec_valid_o && !dec_ready_i |=> dec_valid_o && $stable(dec_req_o));

endmodule

/* lookup/way_array.sv */
`timescale 1ns/1ps
`include "dcache_settings.svh"

module way_array #(
  parameter type payload_t = logic
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          rd_en_i,
  input  logic                          wr_en_i,
  input  logic [`DCACHE_INDEX_BITS-1:0] index_i,
  input  payload_t                      wdata_i,
  output payload_t                      rdata_o
);

  // one entry per set
  payload_t mem_q [`DCACHE_SETS];
  payload_t rdata_q;

  // ------------------------------
  // storage
  // ------------------------------

  // cleared on reset so every tag starts out invalid
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `DCACHE_SETS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wr_en_i) begin
      mem_q[index_i] <= wdata_i;
    end
  end

  // ------------------------------
  // read port
  // ------------------------------

  // data shows up the cycle after rd_en_i
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rdata_q <= mem_q[index_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

/* lookup/lookup_fsm.sv */
`timescale 1ns/1ps
`include "dcache_settings.svh"

module lookup_fsm (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // decoded request
  input  logic                         dec_valid_i,
  input  dcache_pkg::dec_req_t         dec_req_i,
  output logic                         dec_ready_o,
  // miss and write-through port
  output logic                         miss_req_valid_o,
  output dcache_pkg::miss_req_t        miss_req_o,
  input  logic                         miss_req_ready_i,
  input  logic                         refill_valid_i,
  input  dcache_pkg::refill_t          refill_i,
  // towards the response stage
  output logic                         sel_valid_o,
  output dcache_pkg::sel_src_e         sel_src_o,
  output dcache_pkg::line_t            sel_line_o,
  output logic [`DCACHE_WOFF_BITS-1:0] sel_offset_o,
  output logic [`DCACHE_ID_BITS-1:0]   sel_id_o
);

  import dcache_pkg::*;

  localparam int unsigned WAYS     = `DCACHE_WAYS;
  localparam int unsigned WAY_BITS = (WAYS > 1) ? $clog2(WAYS) : 1;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    STORE_WRITE,
    MISS_REQ,
    REFILL_WAIT
  } state_e;

  state_e                        state_q, state_d;
  dec_req_t                      req_q;
  logic [WAYS-1:0]               hit_way, hit_way_q, victim_oh;
  line_t                         hit_line, merged_line, line_q;
  logic [WAY_BITS-1:0]           rr_q [`DCACHE_SETS];
  logic [WAYS-1:0]               rd_en, tag_we, data_we;
  logic [`DCACHE_INDEX_BITS-1:0] arr_index;
  tag_entry_t                    tag_wdata;
  tag_entry_t                    tag_rdata [WAYS];
  line_t                         line_wdata;
  line_t                         line_rdata [WAYS];
  logic                          sel_fire;
  sel_src_e                      sel_src_d;
  line_t                         sel_line_d;

  // ------------------------------
  // tag and data arrays
  // ------------------------------
  for (genvar w = 0; w < WAYS; w++) begin : g_way
    way_array #(.payload_t(tag_entry_t)) tag_array_i (
      .clk_i, .rst_ni, .rd_en_i(rd_en[w]), .wr_en_i(tag_we[w]), .index_i(arr_index),
      .wdata_i(tag_wdata), .rdata_o(tag_rdata[w])
    );
    way_array #(.payload_t(line_t)) data_array_i (
      .clk_i, .rst_ni, .rd_en_i(rd_en[w]), .wr_en_i(data_we[w]), .index_i(arr_index),
      .wdata_i(line_wdata), .rdata_o(line_rdata[w])
    );
  end

  // new requests index with the incoming set, everything else with the held one
  assign arr_index = (state_q == IDLE) ? dec_req_i.index : req_q.index;
  // a refill always lands with a valid tag
  assign tag_wdata = '{valid: 1'b1, tag: req_q.tag};

  // tag compare, and an or-mux over the ways for the hit line
  always_comb begin
    hit_line = '0;
    for (int w = 0; w < WAYS; w++) begin
      hit_way[w] = tag_rdata[w].valid && (tag_rdata[w].tag == req_q.tag);
      if (hit_way[w]) begin
        hit_line = hit_line | line_rdata[w];
      end
    end
  end

  // store data merged byte by byte into the hit line
  always_comb begin
    merged_line = hit_line;
    for (int b = 0; b < `DCACHE_BE_BITS; b++) begin
      if (req_q.be[b]) begin
        merged_line[req_q.offset*`DCACHE_WORD_BITS + 8*b +: 8] = req_q.wdata[8*b +: 8];
      end
    end
  end

  // refill victim from the per-set round-robin pointer
  always_comb begin
    victim_oh = '0;
    victim_oh[rr_q[req_q.index]] = 1'b1;
  end

  // the held request doubles as the memory request
  always_comb begin
    miss_req_o.addr   = {req_q.tag, req_q.index, {`DCACHE_OFFSET_BITS{1'b0}}};
    miss_req_o.we     = req_q.we;
    miss_req_o.be     = req_q.be;
    miss_req_o.wdata  = req_q.wdata;
    miss_req_o.offset = req_q.offset;
  end

  // ------------------------------
  // lookup FSM
  // ------------------------------
  always_comb begin
    state_d          = state_q;
    dec_ready_o      = 1'b0;
    rd_en            = '0;
    tag_we           = '0;
    data_we          = '0;
    line_wdata       = line_q;
    miss_req_valid_o = 1'b0;
    sel_fire         = 1'b0;
    sel_src_d        = SEL_HIT;
    sel_line_d       = hit_line;
    case (state_q)
      IDLE: begin
        dec_ready_o = 1'b1;
        // read every way of the set as the request is taken
        if (dec_valid_i) begin
          rd_en   = '1;
          state_d = LOOKUP;
        end
      end
      LOOKUP: begin
        if (|hit_way) begin
          if (req_q.we) begin
            state_d = STORE_WRITE;
          end else begin
            sel_fire = 1'b1;
            state_d  = IDLE;
          end
        end else begin
          state_d = MISS_REQ;
        end
      end
      STORE_WRITE: begin
        // merged line goes back while the write-through waits for memory
        data_we          = hit_way_q;
        miss_req_valid_o = 1'b1;
        if (miss_req_ready_i) begin
          sel_fire  = 1'b1;
          sel_src_d = SEL_STORE;
          state_d   = IDLE;
        end
      end
      MISS_REQ: begin
        miss_req_valid_o = 1'b1;
        if (miss_req_ready_i) begin
          // store miss is done once memory has it, no allocate
          if (req_q.we) begin
            sel_fire  = 1'b1;
            sel_src_d = SEL_STORE;
            state_d   = IDLE;
          end else begin
            state_d = REFILL_WAIT;
          end
        end
      end
      REFILL_WAIT: begin
        if (refill_valid_i) begin
          tag_we     = victim_oh;
          data_we    = victim_oh;
          line_wdata = refill_i.data;
          sel_fire   = 1'b1;
          sel_src_d  = SEL_REFILL;
          sel_line_d = refill_i.data;
          state_d    = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  // ------------------------------
  // registers
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      sel_valid_o <= 1'b0;
      for (int s = 0; s < `DCACHE_SETS; s++) begin
        rr_q[s] <= '0;
      end
    end else begin
      state_q     <= state_d;
      sel_valid_o <= sel_fire;
      // advance the pointer of the refilled set
      if (state_q == REFILL_WAIT && refill_valid_i) begin
        if (rr_q[req_q.index] == WAY_BITS'(WAYS - 1)) begin
          rr_q[req_q.index] <= '0;
        end else begin
          rr_q[req_q.index] <= rr_q[req_q.index] + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (dec_valid_i && dec_ready_o) begin
      req_q <= dec_req_i;
    end
    // keep the hit way and merged line for the store write
    if (state_q == LOOKUP) begin
      hit_way_q <= hit_way;
      line_q    <= merged_line;
    end
    if (sel_fire) begin
      sel_src_o    <= sel_src_d;
      sel_line_o   <= sel_line_d;
      sel_offset_o <= req_q.offset;
      sel_id_o     <= req_q.id;
    end
  end

  // a tag lives in at most one way of a set
  a_hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == LOOKUP) |-> $onehot0(hit_way));

  a_miss_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    miss_req_valid_o && !miss_req_ready_i |=> miss_req_valid_o && $stable(miss_req_o));

endmodule

/* source/resp_select.sv */
`timescale 1ns/1ps
`include "dcache_settings.svh"

module resp_select (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         sel_valid_i,
  input  dcache_pkg::sel_src_e         sel_src_i,
  input  dcache_pkg::line_t            sel_line_i,
  input  logic [`DCACHE_WOFF_BITS-1:0] sel_offset_i,
  input  logic [`DCACHE_ID_BITS-1:0]   sel_id_i,
  output logic                         rsp_valid_o,
  output dcache_pkg::core_rsp_t        rsp_o
);

  import dcache_pkg::*;

  // line viewed as an array of words
  logic [`DCACHE_WORDS-1:0][`DCACHE_WORD_BITS-1:0] words;
  core_rsp_t                                       rsp_d;

  assign words = sel_line_i;

  // stores answer with zero data, hit and refill pick the addressed word
  always_comb begin
    rsp_d.id    = sel_id_i;
    rsp_d.rdata = (sel_src_i == SEL_STORE) ? '0 : words[sel_offset_i];
  end

  // ------------------------------
  // response register
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= sel_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (sel_valid_i) begin
      rsp_o <= rsp_d;
    end
  end

endmodule

/* source/dcache_ctrl_top.sv */
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_ctrl_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // core request
  input  logic                  core_req_valid_i,
  input  dcache_pkg::core_req_t core_req_i,
  output logic                  core_req_ready_o,
  // core response, no back-pressure
  output logic                  core_rsp_valid_o,
  output dcache_pkg::core_rsp_t core_rsp_o,
  // memory request, loads and write-through stores
  output logic                  miss_req_valid_o,
  output dcache_pkg::miss_req_t miss_req_o,
  input  logic                  miss_req_ready_i,
  // refill line for load misses
  input  logic                  refill_valid_i,
  input  dcache_pkg::refill_t   refill_i
);

  import dcache_pkg::*;

  // ------------------------------
  // decode to lookup
  // ------------------------------
  logic     dec_valid;
  logic     dec_ready;
  dec_req_t dec_req;

  // ------------------------------
  // lookup to response
  // ------------------------------
  logic                         sel_valid;
  sel_src_e                     sel_src;
  line_t                        sel_line;
  logic [`DCACHE_WOFF_BITS-1:0] sel_offset;
  logic [`DCACHE_ID_BITS-1:0]   sel_id;

  // request register and address split
  req_decode req_decode_i (
    .clk_i,
    .rst_ni,
    .req_valid_i (core_req_valid_i),
    .req_i       (core_req_i),
    .req_ready_o (core_req_ready_o),
    .dec_valid_o (dec_valid),
    .dec_req_o   (dec_req),
    .dec_ready_i (dec_ready)
  );

  // tag compare, store merge, miss and refill handling
  lookup_fsm lookup_fsm_i (
    .clk_i,
    .rst_ni,
    .dec_valid_i      (dec_valid),
    .dec_req_i        (dec_req),
    .dec_ready_o      (dec_ready),
    .miss_req_valid_o (miss_req_valid_o),
    .miss_req_o       (miss_req_o),
    .miss_req_ready_i (miss_req_ready_i),
    .refill_valid_i   (refill_valid_i),
    .refill_i         (refill_i),
    .sel_valid_o      (sel_valid),
    .sel_src_o        (sel_src),
    .sel_line_o       (sel_line),
    .sel_offset_o     (sel_offset),
    .sel_id_o         (sel_id)
  );

  // word pick and response register
  resp_select resp_select_i (
    .clk_i,
    .rst_ni,
    .sel_valid_i  (sel_valid),
    .sel_src_i    (sel_src),
    .sel_line_i   (sel_line),
    .sel_offset_i (sel_offset),
    .sel_id_i     (sel_id),
    .rsp_valid_o  (core_rsp_valid_o),
    .rsp_o        (core_rsp_o)
  );

endmodule

/* bench/tb_mem_model.sv */
`timescale 1ns/1ps

module tb_mem_model (
  input  logic                  clk_i,
  // miss and write-through requests from the DUT
  input  logic                  req_valid_i,
  input  dcache_pkg::miss_req_t req_i,
  output logic                  req_ready_o,
  // refill line for loads
  output logic                  refill_valid_o,
  output dcache_pkg::refill_t   refill_o,
  output logic [15:0]           req_count_o
);

  import dcache_pkg::*;

  // words written by stores, everything else follows the fill rule
  logic [63:0] mem [logic [28:0]];
  int          seed;
  logic        pend;
  logic [31:0] pend_addr;
  int          pend_wait;

  // initial memory word, a function of the full word address
  function automatic logic [63:0] fill_word(input logic [31:0] addr);
    return {addr ^ 32'h3c5a_96e1, ~addr};
  endfunction

  function automatic logic [63:0] read_word(input logic [31:0] addr);
    if (mem.exists(addr[31:3])) begin
      return mem[addr[31:3]];
    end
    return fill_word({addr[31:3], 3'b000});
  endfunction

  // byte-enabled write of one word
  task automatic write_word(input miss_req_t req);
    logic [31:0] addr;
    logic [63:0] word;
    addr = req.addr | (32'(req.offset) << 3);
    word = read_word(addr);
    for (int b = 0; b < 8; b++) begin
      if (req.be[b]) begin
        word[8*b +: 8] = req.wdata[8*b +: 8];
      end
    end
    mem[addr[31:3]] = word;
  endtask

  // ------------------------------
  // one process drives all outputs on the falling edge
  // ------------------------------
  initial begin
    seed           = 32'h1eb7_abf0;
    req_ready_o    = 1'b0;
    refill_valid_o = 1'b0;
    refill_o       = '0;
    req_count_o    = '0;
    pend           = 1'b0;
    pend_addr      = '0;
    pend_wait      = 0;
    forever begin
      @(negedge clk_i);
      // refill pulse lasts one cycle
      refill_valid_o = 1'b0;
      if (pend) begin
        if (pend_wait == 0) begin
          refill_o.data  = {read_word(pend_addr + 32'd8), read_word(pend_addr)};
          refill_valid_o = 1'b1;
          pend           = 1'b0;
        end else begin
          pend_wait--;
        end
      end
      // ready low about one cycle in four
      req_ready_o = ($random(seed) & 3) != 0;
      // valid is stable here, so the transfer happens at the next rising edge
      if (req_valid_i && req_ready_o) begin
        req_count_o++;
        if (req_i.we) begin
          write_word(req_i);
        end else begin
          pend      = 1'b1;
          pend_addr = req_i.addr;
          pend_wait = $random(seed) & 3;
        end
      end
    end
  end

endmodule

/* bench/tb_dcache_ctrl.sv */
`timescale 1ns/1ps

module tb_dcache_ctrl;

  import dcache_pkg::*;

  localparam int NUM_OPS     = 17;
  localparam int REQ_TIMEOUT = 200;
  localparam int RSP_TIMEOUT = 1000;

  // one table row
  // misses counts the transfers it causes at the miss port
  typedef struct packed {
    logic        we;
    logic [31:0] addr;
    logic [7:0]  be;
    logic [63:0] wdata;
    logic [3:0]  id;
    logic [1:0]  misses;
    logic        sync;
  } op_t;

  typedef struct packed {
    logic [3:0]  id;
    logic [63:0] rdata;
    logic        check_lat;
    logic [31:0] accept_cycle;
  } exp_rsp_t;

  logic        clk_i;
  logic        rst_ni;
  logic        core_req_valid_i;
  core_req_t   core_req_i;
  logic        core_req_ready_o;
  logic        core_rsp_valid_o;
  core_rsp_t   core_rsp_o;
  logic        miss_req_valid_o;
  miss_req_t   miss_req_o;
  logic        miss_req_ready_i;
  logic        refill_valid_i;
  refill_t     refill_i;
  logic [15:0] miss_count;

  op_t         ops [NUM_OPS];
  exp_rsp_t    exp_q [$];
  exp_rsp_t    rsp_exp;
  logic [63:0] sb_mem [logic [28:0]];
  logic [31:0] cycle_cnt = '0;
  logic [15:0] exp_misses;
  logic        idle;

  dcache_ctrl_top dut_i (
    .clk_i, .rst_ni, .core_req_valid_i, .core_req_i, .core_req_ready_o,
    .core_rsp_valid_o, .core_rsp_o, .miss_req_valid_o, .miss_req_o,
    .miss_req_ready_i, .refill_valid_i, .refill_i
  );

  tb_mem_model mem_i (
    .clk_i, .req_valid_i(miss_req_valid_o), .req_i(miss_req_o),
    .req_ready_o(miss_req_ready_i), .refill_valid_o(refill_valid_i),
    .refill_o(refill_i), .req_count_o(miss_count)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 32'd1;

  // ------------------------------
  // error handling
  // ------------------------------
  task automatic abort_run();
    $display("Something failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    abort_run();
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    abort_run();
  endtask

  // ------------------------------
  // reference model
  // ------------------------------

  // same memory fill rule as the memory model
  function automatic logic [63:0] fill_word(input logic [31:0] addr);
    return {addr ^ 32'h3c5a_96e1, ~addr};
  endfunction

  function automatic logic [63:0] sb_read(input logic [31:0] addr);
    if (sb_mem.exists(addr[31:3])) begin
      return sb_mem[addr[31:3]];
    end
    return fill_word({addr[31:3], 3'b000});
  endfunction

  function automatic op_t load_op(input logic [31:0] addr, input logic [3:0] id,
                                  input logic [1:0] misses, input logic sync);
    return '{we: 1'b0, addr: addr, be: 8'h00, wdata: '0, id: id, misses: misses, sync: sync};
  endfunction

  function automatic op_t store_op(input logic [31:0] addr, input logic [7:0] be,
                                   input logic [63:0] wdata, input logic [3:0] id,
                                   input logic [1:0] misses, input logic sync);
    return '{we: 1'b1, addr: addr, be: be, wdata: wdata, id: id, misses: misses, sync: sync};
  endfunction

  // drive one request and predict its response
  // returns on the falling edge after acceptance
  task automatic issue_op(input op_t op, input logic lat_ok);
    int          t;
    logic [63:0] word;
    exp_rsp_t    e;
    core_req_i       = '{addr: op.addr, we: op.we, be: op.be, wdata: op.wdata, id: op.id};
    core_req_valid_i = 1'b1;
    t = 0;
    while (!core_req_ready_o) begin
      @(negedge clk_i);
      t++;
      if (t > REQ_TIMEOUT) report_failure("timed out waiting for core_req_ready_o");
    end
    word = sb_read(op.addr);
    if (op.we) begin
      for (int b = 0; b < 8; b++) begin
        if (op.be[b]) word[8*b +: 8] = op.wdata[8*b +: 8];
      end
      sb_mem[op.addr[31:3]] = word;
      e.rdata = '0;
    end else begin
      e.rdata = word;
    end
    // only a load hit issued to an idle DUT has a fixed latency
    e.id           = op.id;
    e.check_lat    = lat_ok && !op.we && (op.misses == 2'd0);
    e.accept_cycle = cycle_cnt + 32'd1;
    exp_q.push_back(e);
    exp_misses += 16'(op.misses);
    @(negedge clk_i);
    core_req_valid_i = 1'b0;
  endtask

  // wait until every outstanding response is back
  task automatic wait_drain();
    int t;
    t = 0;
    @(posedge clk_i);
    while (exp_q.size() != 0) begin
      t++;
      if (t > RSP_TIMEOUT) report_failure("timed out waiting for outstanding responses");
      @(posedge clk_i);
    end
    @(negedge clk_i);
  endtask

  // in-order response checker against the queue
  always @(negedge clk_i) begin
    if (rst_ni && core_rsp_valid_o) begin
      assert (exp_q.size() != 0)
        else report_failure("a response arrived with no request outstanding");
      rsp_exp = exp_q.pop_front();
      assert (core_rsp_o.id == rsp_exp.id)
        else report_mismatch($sformatf("response id %0d, expected %0d",
                                       core_rsp_o.id, rsp_exp.id));
      assert (core_rsp_o.rdata == rsp_exp.rdata)
        else report_mismatch($sformatf("id %0d data %h, expected %h", rsp_exp.id,
                                       core_rsp_o.rdata, rsp_exp.rdata));
      if (rsp_exp.check_lat) begin
        assert (cycle_cnt - rsp_exp.accept_cycle == 32'd3)
          else report_mismatch($sformatf("id %0d hit latency %0d cycles, expected 3",
                                         rsp_exp.id, cycle_cnt - rsp_exp.accept_cycle));
      end
    end
  end

  // ------------------------------
  // stimulus
  // ------------------------------
  initial begin
    rst_ni           = 1'b0;
    core_req_valid_i = 1'b0;
    core_req_i       = '0;
    exp_misses       = '0;
    idle             = 1'b1;
    // a first miss and then a hit on the same word
    ops[0]  = load_op(32'h0000_0108, 4'd1, 2'd1, 1'b1);
    ops[1]  = load_op(32'h0000_0108, 4'd2, 2'd0, 1'b1);
    // partial store hit with write-through and a read back
    ops[2]  = store_op(32'h0000_0100, 8'h0f, 64'h1122_3344_5566_7788, 4'd3, 2'd1, 1'b1);
    ops[3]  = load_op(32'h0000_0100, 4'd4, 2'd0, 1'b1);
    // store miss without allocate
    ops[4]  = store_op(32'h0000_0a28, 8'hf0, 64'hdead_beef_0bad_f00d, 4'd5, 2'd1, 1'b1);
    ops[5]  = load_op(32'h0000_0a28, 4'd6, 2'd1, 1'b1);
    // three tags on set 4 force a round-robin eviction
    ops[6]  = load_op(32'h0000_1040, 4'd7, 2'd1, 1'b1);
    ops[7]  = load_op(32'h0000_2048, 4'd8, 2'd1, 1'b1);
    ops[8]  = load_op(32'h0000_3040, 4'd9, 2'd1, 1'b1);
    ops[9]  = load_op(32'h0000_1040, 4'd10, 2'd1, 1'b1);
    ops[10] = load_op(32'h0000_3048, 4'd11, 2'd0, 1'b1);
    // back to back burst under ready throttling
    ops[11] = load_op(32'h0000_0560, 4'd12, 2'd1, 1'b0);
    ops[12] = store_op(32'h0000_0568, 8'h3c, 64'h0102_0304_0506_0708, 4'd13, 2'd1, 1'b0);
    ops[13] = load_op(32'h0000_0568, 4'd14, 2'd0, 1'b0);
    ops[14] = load_op(32'h0000_0108, 4'd15, 2'd0, 1'b0);
    ops[15] = store_op(32'h0000_0c70, 8'hff, 64'hcafe_f00d_1234_5678, 4'd0, 2'd1, 1'b0);
    ops[16] = load_op(32'h0000_0c70, 4'd1, 2'd1, 1'b1);

    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    assert (core_req_ready_o && !core_rsp_valid_o && !miss_req_valid_o)
      else report_mismatch("handshake outputs not in their reset state");

    for (int i = 0; i < NUM_OPS; i++) begin
      issue_op(ops[i], idle);
      if (ops[i].sync) begin
        wait_drain();
        assert (miss_count == exp_misses)
          else report_mismatch($sformatf("row %0d miss port count %0d, expected %0d", i,
                                         miss_count, exp_misses));
      end
      idle = ops[i].sync;
    end

    $display("Everything OK");
    $finish;
  end

endmodule

/* dcache_ctrl.f */
+incdir+common
common/dcache_pkg.sv
source/req_decode.sv
lookup/way_array.sv
lookup/lookup_fsm.sv
source/resp_select.sv
source/dcache_ctrl_top.sv
bench/tb_mem_model.sv
bench/tb_dcache_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

rm -f sim.log
verilator --binary --timing --assert -j 0 \
  --timescale 1ns/1ps \
  --top-module tb_dcache_ctrl \
  -Mdir obj_dir \
  -f dcache_ctrl.f

./obj_dir/Vtb_dcache_ctrl > sim.log 2>&1 || true
cat sim.log

if grep -q "Something failed" sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "Everything OK" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"
